//--- verilog/pawn_eval_pkg.sv
// pawn evaluation shared definitions
// piece codes, board geometry, latency and score weight tables
package pawn_eval_pkg;

   localparam int piece_width = 4;
   localparam int board_squares = 64;                    // index is row * 8 + col
   localparam int board_width = board_squares * piece_width;

   localparam int eval_default_width = 16;

   // board_valid to eval_valid
   localparam int pipe_latency = 6;

   // square contents, black codes are white plus 8
   typedef enum logic [piece_width-1:0] {
      empty        = 4'd0,
      white_pawn   = 4'd1,
      white_knight = 4'd2,
      white_bishop = 4'd3,
      white_rook   = 4'd4,
      white_queen  = 4'd5,
      white_king   = 4'd6,
      black_pawn   = 4'd9,
      black_knight = 4'd10,
      black_bishop = 4'd11,
      black_rook   = 4'd12,
      black_queen  = 4'd13,
      black_king   = 4'd14
   } piece_e;

   // isolated penalty by column
   localparam logic signed [eval_default_width-1:0] isolated_mg [8] = '{
      -5, -7, -8, -9, -9, -8, -7, -5
   };
   localparam logic signed [eval_default_width-1:0] isolated_eg [8] = '{
      -8, -10, -12, -14, -14, -12, -10, -8
   };

   // doubled penalty by distance to the leading pawn, entry 0 unused
   localparam logic signed [eval_default_width-1:0] doubled_mg [6] = '{
      0, -11, -9, -7, -5, -4
   };
   localparam logic signed [eval_default_width-1:0] doubled_eg [6] = '{
      0, -28, -24, -20, -16, -12
   };

   // passed bonus by flipped row, rows 0 and 7 never hold a pawn
   localparam logic signed [eval_default_width-1:0] passed_mg [8] = '{
      0, 5, 10, 17, 35, 60, 95, 0
   };
   localparam logic signed [eval_default_width-1:0] passed_eg [8] = '{
      0, 10, 17, 25, 45, 80, 130, 0
   };

endpackage

//--- verilog/pawn_board_decode.sv
// pawn bitboard extraction from a full board
// own and enemy pawns in a frame where own pawns advance toward row 7
`timescale 1ns/1ps

module pawn_board_decode #(
   parameter int white_pawns = 1
) (
   input  logic                                    clk,
   input  logic [pawn_eval_pkg::board_width-1:0]   board,
   output logic [pawn_eval_pkg::board_squares-1:0] my_pawns,
   output logic [pawn_eval_pkg::board_squares-1:0] op_pawns
);

   localparam pawn_eval_pkg::piece_e my_code =
      (white_pawns != 0) ? pawn_eval_pkg::white_pawn : pawn_eval_pkg::black_pawn;
   localparam pawn_eval_pkg::piece_e op_code =
      (white_pawns != 0) ? pawn_eval_pkg::black_pawn : pawn_eval_pkg::white_pawn;

   logic [pawn_eval_pkg::board_squares-1:0] my_next;
   logic [pawn_eval_pkg::board_squares-1:0] op_next;

   always_comb
   begin
      logic [2:0]                            src_row;
      logic [pawn_eval_pkg::piece_width-1:0] code;

      my_next = '0;                           // rows 0 and 7 stay clear
      op_next = '0;
      src_row = '0;
      code = '0;
      for (int row = 1; row < 7; row++)
      begin
         for (int col = 0; col < 8; col++)
         begin
            // black reads the board upside down
            src_row = (white_pawns != 0) ? 3'(row) : 3'(7 - row);
            code = board[(src_row * 8 + col) * pawn_eval_pkg::piece_width +:
                         pawn_eval_pkg::piece_width];
            my_next[row * 8 + col] = (code == my_code);
            op_next[row * 8 + col] = (code == op_code);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      my_pawns <= my_next;
      op_pawns <= op_next;
   end

endmodule

//--- verilog/pawn_structure_eval.sv
// isolated and doubled pawn scoring, three register stages
`timescale 1ns/1ps

module pawn_structure_eval #(
   parameter int eval_width = pawn_eval_pkg::eval_default_width
) (
   input  logic                                    clk,
   input  logic [pawn_eval_pkg::board_squares-1:0] my_pawns,
   output logic signed [eval_width-1:0]            struct_mg,
   output logic signed [eval_width-1:0]            struct_eg
);

   logic [7:0] col_has;
   logic [7:0] adj_has;

   logic [pawn_eval_pkg::board_squares-1:0] iso_next;
   logic [pawn_eval_pkg::board_squares-1:0] iso_q;
   logic [2:0]                              dist_next [pawn_eval_pkg::board_squares];
   logic [2:0]                              dist_q [pawn_eval_pkg::board_squares];

   logic signed [eval_width-1:0] col_mg_next [8];
   logic signed [eval_width-1:0] col_eg_next [8];
   logic signed [eval_width-1:0] col_mg_q [8];
   logic signed [eval_width-1:0] col_eg_q [8];
   logic signed [eval_width-1:0] total_mg;
   logic signed [eval_width-1:0] total_eg;

   // stage 1, isolation and doubled distance per square
   always_comb
   begin
      for (int c = 0; c < 8; c++)
      begin
         col_has[c] = 1'b0;
         for (int r = 0; r < 8; r++)
            col_has[c] = col_has[c] | my_pawns[r * 8 + c];
      end
      adj_has = (col_has << 1) | (col_has >> 1);  // edge columns see one side only
      iso_next = my_pawns & ~{8{adj_has}};

      for (int s = 0; s < pawn_eval_pkg::board_squares; s++)
         dist_next[s] = '0;
      for (int r = 1; r < 6; r++)
      begin
         for (int c = 0; c < 8; c++)
         begin
            if (my_pawns[r * 8 + c])
            begin
               // last hit is the most advanced pawn ahead
               for (int a = r + 1; a < 7; a++)
                  if (my_pawns[a * 8 + c])
                     dist_next[r * 8 + c] = 3'(a - r);
            end
         end
      end
   end

   // stage 2 terms, summed per column
   always_comb
   begin
      for (int c = 0; c < 8; c++)
      begin
         col_mg_next[c] = '0;
         col_eg_next[c] = '0;
         for (int r = 1; r < 7; r++)
         begin
            if (iso_q[r * 8 + c])
            begin
               col_mg_next[c] = col_mg_next[c] + eval_width'(pawn_eval_pkg::isolated_mg[c]);
               col_eg_next[c] = col_eg_next[c] + eval_width'(pawn_eval_pkg::isolated_eg[c]);
            end
            if (dist_q[r * 8 + c] != 3'd0)
            begin
               col_mg_next[c] = col_mg_next[c] +
                                eval_width'(pawn_eval_pkg::doubled_mg[dist_q[r * 8 + c]]);
               col_eg_next[c] = col_eg_next[c] +
                                eval_width'(pawn_eval_pkg::doubled_eg[dist_q[r * 8 + c]]);
            end
         end
      end
   end

   // stage 3 input, column total
   always_comb
   begin
      total_mg = '0;
      total_eg = '0;
      for (int c = 0; c < 8; c++)
      begin
         total_mg = total_mg + col_mg_q[c];
         total_eg = total_eg + col_eg_q[c];
      end
   end

   always_ff @(posedge clk)
   begin
      iso_q <= iso_next;
      dist_q <= dist_next;
      col_mg_q <= col_mg_next;
      col_eg_q <= col_eg_next;
      struct_mg <= total_mg;
      struct_eg <= total_eg;
   end

endmodule

//--- verilog/passed_pawn_eval.sv
// passed pawn detection and bonus on the leading pawn of each column
`timescale 1ns/1ps

module passed_pawn_eval #(
   parameter int eval_width = pawn_eval_pkg::eval_default_width
) (
   input  logic                                    clk,
   input  logic [pawn_eval_pkg::board_squares-1:0] my_pawns,
   input  logic [pawn_eval_pkg::board_squares-1:0] op_pawns,
   output logic signed [eval_width-1:0]            passed_mg,
   output logic signed [eval_width-1:0]            passed_eg
);

   logic [2:0]                              adv_next [8];
   logic [2:0]                              adv_q [8];   // 0 means no pawn
   logic [pawn_eval_pkg::board_squares-1:0] op_q;

   logic signed [eval_width-1:0] col_mg_next [8];
   logic signed [eval_width-1:0] col_eg_next [8];
   logic signed [eval_width-1:0] col_mg_q [8];
   logic signed [eval_width-1:0] col_eg_q [8];
   logic signed [eval_width-1:0] total_mg;
   logic signed [eval_width-1:0] total_eg;

   always_comb
   begin
      for (int c = 0; c < 8; c++)
      begin
         adv_next[c] = '0;
         for (int r = 1; r < 7; r++)
            if (my_pawns[r * 8 + c])
               adv_next[c] = 3'(r);
      end
   end

   always_comb
   begin
      logic       blocked;
      logic [7:0] row_bits;
      logic [7:0] span;

      blocked = 1'b0;
      row_bits = '0;
      span = '0;
      for (int c = 0; c < 8; c++)
      begin
         blocked = 1'b0;
         for (int r = 1; r < 7; r++)
         begin
            row_bits = op_q[r * 8 +: 8];
            span = row_bits | (row_bits << 1) | (row_bits >> 1);  // own and adjacent columns
            if (r > adv_q[c] && span[c])
               blocked = 1'b1;
         end
         col_mg_next[c] = '0;
         col_eg_next[c] = '0;
         if (adv_q[c] != 3'd0 && !blocked)
         begin
            col_mg_next[c] = eval_width'(pawn_eval_pkg::passed_mg[adv_q[c]]);
            col_eg_next[c] = eval_width'(pawn_eval_pkg::passed_eg[adv_q[c]]);
         end
      end
   end

   always_comb
   begin
      total_mg = '0;
      total_eg = '0;
      for (int c = 0; c < 8; c++)
      begin
         total_mg = total_mg + col_mg_q[c];
         total_eg = total_eg + col_eg_q[c];
      end
   end

   always_ff @(posedge clk)
   begin
      adv_q <= adv_next;
      op_q <= op_pawns;                       // kept in step with adv_q
      col_mg_q <= col_mg_next;
      col_eg_q <= col_eg_next;
      passed_mg <= total_mg;
      passed_eg <= total_eg;
   end

endmodule

//--- verilog/evaluate_pawns.sv
// pawn structure evaluation pipeline
// board in, signed mg and eg scores out a fixed number of cycles later
`timescale 1ns/1ps

module evaluate_pawns #(
   parameter int eval_width = pawn_eval_pkg::eval_default_width,
   parameter int white_pawns = 1
) (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  board_valid,
   input  logic [pawn_eval_pkg::board_width-1:0] board,
   output logic signed [eval_width-1:0]          eval_mg,
   output logic signed [eval_width-1:0]          eval_eg,
   output logic                                  eval_valid
);

   logic [pawn_eval_pkg::board_squares-1:0] my_pawns;
   logic [pawn_eval_pkg::board_squares-1:0] op_pawns;

   logic signed [eval_width-1:0] struct_mg;
   logic signed [eval_width-1:0] struct_eg;
   logic signed [eval_width-1:0] passed_mg;
   logic signed [eval_width-1:0] passed_eg;
   logic signed [eval_width-1:0] sum_mg;
   logic signed [eval_width-1:0] sum_eg;

   logic [pawn_eval_pkg::pipe_latency-1:0] valid_pipe;

   pawn_board_decode #(
      .white_pawns (white_pawns)
   ) u_decode (
      .clk      (clk),
      .board    (board),
      .my_pawns (my_pawns),
      .op_pawns (op_pawns)
   );

   pawn_structure_eval #(
      .eval_width (eval_width)
   ) u_structure (
      .clk       (clk),
      .my_pawns  (my_pawns),
      .struct_mg (struct_mg),
      .struct_eg (struct_eg)
   );

   passed_pawn_eval #(
      .eval_width (eval_width)
   ) u_passed (
      .clk       (clk),
      .my_pawns  (my_pawns),
      .op_pawns  (op_pawns),
      .passed_mg (passed_mg),
      .passed_eg (passed_eg)
   );

   always_ff @(posedge clk)
   begin
      if (rst)
         valid_pipe <= '0;
      else
         valid_pipe <= {valid_pipe[pawn_eval_pkg::pipe_latency-2:0], board_valid};
   end

   assign eval_valid = valid_pipe[pawn_eval_pkg::pipe_latency-1];

   always_ff @(posedge clk)
   begin
      sum_mg <= struct_mg + passed_mg;
      sum_eg <= struct_eg + passed_eg;
      // black was scored in the flipped frame
      eval_mg <= (white_pawns != 0) ? sum_mg : -sum_mg;
      eval_eg <= (white_pawns != 0) ? sum_eg : -sum_eg;
   end

endmodule

//--- verification/evaluate_pawns_props.sv
// timing and output checks for the pawn evaluation pipeline
`timescale 1ns/1ps

module evaluate_pawns_props #(
   parameter int eval_width = pawn_eval_pkg::eval_default_width
) (
   input logic                         clk,
   input logic                         rst,
   input logic                         board_valid,
   input logic signed [eval_width-1:0] eval_mg,
   input logic signed [eval_width-1:0] eval_eg,
   input logic                         eval_valid
);

   logic [3:0] since_rst;                     // saturates at pipe_latency

   always_ff @(posedge clk)
   begin
      if (rst)
         since_rst <= '0;
      else if (since_rst < pawn_eval_pkg::pipe_latency)
         since_rst <= since_rst + 4'd1;
   end

   valid_low_after_reset: assert property (@(posedge clk) rst |=> !eval_valid)
      else $error("eval_valid high in the cycle after reset");

   valid_latency: assert property (@(posedge clk)
      (since_rst >= pawn_eval_pkg::pipe_latency) |->
         (eval_valid == $past(board_valid, pawn_eval_pkg::pipe_latency)))
      else $error("eval_valid does not follow board_valid by the pipeline latency");

   scores_known: assert property (@(posedge clk) eval_valid |-> !$isunknown({eval_mg, eval_eg}))
      else $error("eval scores unknown while eval_valid is high");

endmodule

bind evaluate_pawns evaluate_pawns_props #(
   .eval_width (eval_width)
) u_props (
   .clk         (clk),
   .rst         (rst),
   .board_valid (board_valid),
   .eval_mg     (eval_mg),
   .eval_eg     (eval_eg),
   .eval_valid  (eval_valid)
);

//--- verification/tb_evaluate_pawns.sv
// testbench for the pawn evaluation pipeline
// white and black DUTs on shared stimulus against a reference model
`timescale 1ns/1ps

module tb_evaluate_pawns;

   localparam int eval_width = pawn_eval_pkg::eval_default_width;
   localparam int bw = pawn_eval_pkg::board_width;
   localparam int max_cycles = 2000;          // about 300 boards with gaps up to 2 plus margin

   logic clk;
   logic rst;
   logic board_valid;
   logic [bw-1:0] board;
   logic signed [eval_width-1:0] eval_mg_w;
   logic signed [eval_width-1:0] eval_eg_w;
   logic signed [eval_width-1:0] eval_mg_b;
   logic signed [eval_width-1:0] eval_eg_b;
   logic eval_valid_w;
   logic eval_valid_b;

   integer seed = 32'hd88;
   int cycle_count = 0;
   int mismatch_count = 0;
   int fault_count = 0;
   int checked_count = 0;

   // expected {mg_w, eg_w, mg_b, eg_b} and the cycle each is due
   logic [4*eval_width-1:0] exp_q [$];
   int due_q [$];
   logic signed [eval_width-1:0] last_mg_w;
   logic signed [eval_width-1:0] last_eg_w;
   logic signed [eval_width-1:0] last_mg_b;
   logic signed [eval_width-1:0] last_eg_b;

   evaluate_pawns #(
      .eval_width  (eval_width),
      .white_pawns (1)
   ) u_dut (
      .clk         (clk),
      .rst         (rst),
      .board_valid (board_valid),
      .board       (board),
      .eval_mg     (eval_mg_w),
      .eval_eg     (eval_eg_w),
      .eval_valid  (eval_valid_w)
   );

   evaluate_pawns #(
      .eval_width  (eval_width),
      .white_pawns (0)
   ) u_dut_black (
      .clk         (clk),
      .rst         (rst),
      .board_valid (board_valid),
      .board       (board),
      .eval_mg     (eval_mg_b),
      .eval_eg     (eval_eg_b),
      .eval_valid  (eval_valid_b)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // expected {mg, eg} for one side
   function automatic logic [2*eval_width-1:0] ref_eval(input logic [bw-1:0] b,
                                                         input logic white);
      bit mine [8][8];
      bit theirs [8][8];
      bit has_col [8];
      logic [3:0] code;
      int mg;
      int eg;
      int src;
      int lead;
      int cc;
      bit passed;

      mg = 0;
      eg = 0;
      for (int r = 0; r < 8; r++)
         for (int c = 0; c < 8; c++)
         begin
            mine[r][c] = 0;
            theirs[r][c] = 0;
         end
      for (int r = 1; r < 7; r++)
         for (int c = 0; c < 8; c++)
         begin
            src = white ? r : 7 - r;
            code = b[(src * 8 + c) * 4 +: 4];
            mine[r][c] = (code == (white ? 4'd1 : 4'd9));
            theirs[r][c] = (code == (white ? 4'd9 : 4'd1));
         end
      for (int c = 0; c < 8; c++)
      begin
         has_col[c] = 0;
         for (int r = 1; r < 7; r++)
            has_col[c] = has_col[c] | mine[r][c];
      end
      for (int r = 1; r < 7; r++)
         for (int c = 0; c < 8; c++)
            if (mine[r][c])
            begin
               if (!(c > 0 && has_col[c-1]) && !(c < 7 && has_col[c+1]))
               begin
                  mg = mg + pawn_eval_pkg::isolated_mg[c];
                  eg = eg + pawn_eval_pkg::isolated_eg[c];
               end
               lead = 0;
               for (int a = r + 1; a < 7; a++)
                  if (mine[a][c])
                     lead = a;
               if (lead != 0)
               begin
                  mg = mg + pawn_eval_pkg::doubled_mg[lead - r];
                  eg = eg + pawn_eval_pkg::doubled_eg[lead - r];
               end
            end
      for (int c = 0; c < 8; c++)
      begin
         lead = 0;
         for (int r = 1; r < 7; r++)
            if (mine[r][c])
               lead = r;
         passed = (lead != 0);
         for (int r = lead + 1; r < 7; r++)
            for (int d = -1; d < 2; d++)
            begin
               cc = c + d;
               if (cc >= 0 && cc < 8 && theirs[r][cc])
                  passed = 0;
            end
         if (passed)
         begin
            mg = mg + pawn_eval_pkg::passed_mg[lead];
            eg = eg + pawn_eval_pkg::passed_eg[lead];
         end
      end
      if (!white)
      begin
         mg = -mg;
         eg = -eg;
      end
      return {eval_width'(mg), eval_width'(eg)};
   endfunction

   function automatic logic [bw-1:0] put_piece(input logic [bw-1:0] b, input int row,
                                               input int col, input logic [3:0] code);
      logic [bw-1:0] nb;

      nb = b;
      nb[(row * 8 + col) * 4 +: 4] = code;
      return nb;
   endfunction

   // colour swap plus row mirror
   function automatic logic [bw-1:0] mirror_board(input logic [bw-1:0] b);
      logic [bw-1:0] nb;
      logic [3:0] code;

      nb = '0;
      for (int r = 0; r < 8; r++)
         for (int c = 0; c < 8; c++)
         begin
            code = b[((7 - r) * 8 + c) * 4 +: 4];
            if (code != 4'd0)
               code = code ^ 4'd8;
            nb[(r * 8 + c) * 4 +: 4] = code;
         end
      return nb;
   endfunction

   function automatic logic [bw-1:0] random_board();
      logic [bw-1:0] nb;
      int v;

      nb = '0;
      for (int s = 0; s < 64; s++)
      begin
         v = $unsigned($random(seed)) % 16;
         if (v < 5)
            nb[s * 4 +: 4] = 4'd0;
         else if (v < 8)
            nb[s * 4 +: 4] = 4'd1;
         else if (v < 11)
            nb[s * 4 +: 4] = 4'd9;
         else
            nb[s * 4 +: 4] = 4'(v - 9) | (v[0] ? 4'd8 : 4'd0);  // other pieces
      end
      return nb;
   endfunction

   task automatic send_board(input logic [bw-1:0] b);
      @(negedge clk);
      board = b;
      board_valid = 1'b1;
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(negedge clk);
         board_valid = 1'b0;
      end
   endtask

   task automatic drain();
      idle(1);
      while (due_q.size() != 0)
         @(negedge clk);
   endtask

   task automatic check_value(input string name, input logic signed [eval_width-1:0] expected,
                              input logic signed [eval_width-1:0] actual);
      if (actual !== expected)
      begin
         $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
         mismatch_count++;
      end
   endtask

   // black DUT on the mirrored board gives the negated white score
   task automatic check_mirror(input logic [bw-1:0] b);
      logic signed [eval_width-1:0] mg_w;
      logic signed [eval_width-1:0] eg_w;

      send_board(b);
      drain();
      mg_w = last_mg_w;
      eg_w = last_eg_w;
      send_board(mirror_board(b));
      drain();
      check_value("u_dut_black.eval_mg (mirrored)", -mg_w, last_mg_b);
      check_value("u_dut_black.eval_eg (mirrored)", -eg_w, last_eg_b);
   endtask

   task automatic finish_run();
      $display("errors: %0d mismatches, %0d other failures, %0d results checked",
               mismatch_count, fault_count, checked_count);
      if (mismatch_count == 0 && fault_count == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   endtask

   always @(posedge clk)
   begin
      cycle_count++;
      if (!rst && board_valid)
      begin
         exp_q.push_back({ref_eval(board, 1'b1), ref_eval(board, 1'b0)});
         // seen on the falling edge before the edge that samples the result
         due_q.push_back(cycle_count + pawn_eval_pkg::pipe_latency - 1);
      end
   end

   always @(negedge clk)
   begin : check_results
      logic [4*eval_width-1:0] exp;
      int due;

      if (rst)
      begin
         if (cycle_count > 0 && (eval_valid_w !== 1'b0 || eval_valid_b !== 1'b0))
         begin
            $display("eval_valid is not low during reset at %0t", $time);
            fault_count++;
         end
      end
      else
      begin
         if (eval_valid_w !== eval_valid_b)
         begin
            $display("the two DUTs disagree on eval_valid at %0t", $time);
            fault_count++;
         end
         if (due_q.size() > 0 && due_q[0] < cycle_count && eval_valid_w !== 1'b1)
         begin
            $display("result due at cycle %0d never arrived", due_q[0]);
            fault_count++;
            exp = exp_q.pop_front();
            due = due_q.pop_front();
         end
         if (eval_valid_w === 1'b1)
         begin
            if (due_q.size() == 0)
            begin
               $display("eval_valid high at %0t with no result expected", $time);
               fault_count++;
            end
            else
            begin
               exp = exp_q.pop_front();
               due = due_q.pop_front();
               if (due != cycle_count)
               begin
                  $display("result arrived at cycle %0d but was due at %0d", cycle_count, due);
                  fault_count++;
               end
               check_value("u_dut.eval_mg", exp[4*eval_width-1 -: eval_width], eval_mg_w);
               check_value("u_dut.eval_eg", exp[3*eval_width-1 -: eval_width], eval_eg_w);
               check_value("u_dut_black.eval_mg", exp[2*eval_width-1 -: eval_width], eval_mg_b);
               check_value("u_dut_black.eval_eg", exp[eval_width-1 -: eval_width], eval_eg_b);
               last_mg_w = eval_mg_w;
               last_eg_w = eval_eg_w;
               last_mg_b = eval_mg_b;
               last_eg_b = eval_eg_b;
               checked_count++;
            end
         end
      end
   end

   initial
   begin
      wait (cycle_count >= max_cycles);
      $display("timeout, run stopped after %0d cycles", cycle_count);
      fault_count++;
      finish_run();
   end

   initial
   begin
      logic [bw-1:0] b;
      int gap;

      rst = 1'b1;
      board_valid = 1'b0;
      board = '0;
      repeat (10) @(negedge clk);
      rst = 1'b0;

      // empty board and pieces without pawns
      send_board('0);
      b = put_piece('0, 0, 4, pawn_eval_pkg::white_king);
      b = put_piece(b, 7, 4, pawn_eval_pkg::black_king);
      b = put_piece(b, 3, 3, pawn_eval_pkg::white_rook);
      b = put_piece(b, 4, 5, pawn_eval_pkg::black_knight);
      b = put_piece(b, 5, 1, pawn_eval_pkg::black_queen);
      send_board(b);
      drain();

      // isolated pawns then a neighbour that lifts the penalty
      send_board(put_piece('0, 1, 0, pawn_eval_pkg::white_pawn));
      send_board(put_piece('0, 3, 3, pawn_eval_pkg::white_pawn));
      send_board(put_piece('0, 5, 7, pawn_eval_pkg::white_pawn));
      b = put_piece('0, 2, 3, pawn_eval_pkg::white_pawn);
      send_board(put_piece(b, 2, 4, pawn_eval_pkg::white_pawn));
      drain();

      // doubled and tripled columns
      b = put_piece('0, 2, 2, pawn_eval_pkg::white_pawn);
      send_board(put_piece(b, 4, 2, pawn_eval_pkg::white_pawn));
      b = put_piece('0, 1, 5, pawn_eval_pkg::white_pawn);
      b = put_piece(b, 3, 5, pawn_eval_pkg::white_pawn);
      send_board(put_piece(b, 6, 5, pawn_eval_pkg::white_pawn));
      drain();

      // passed pawns on every row then enemy pawns above and below
      for (int r = 1; r < 7; r++)
         send_board(put_piece('0, r, 4, pawn_eval_pkg::white_pawn));
      b = put_piece('0, 3, 4, pawn_eval_pkg::white_pawn);
      send_board(put_piece(b, 5, 4, pawn_eval_pkg::black_pawn));
      send_board(put_piece(b, 5, 5, pawn_eval_pkg::black_pawn));
      send_board(put_piece(b, 2, 3, pawn_eval_pkg::black_pawn));
      drain();

      // side symmetry
      b = put_piece('0, 2, 1, pawn_eval_pkg::white_pawn);
      b = put_piece(b, 4, 1, pawn_eval_pkg::white_pawn);
      b = put_piece(b, 5, 6, pawn_eval_pkg::black_pawn);
      check_mirror(b);
      repeat (4) check_mirror(random_board());

      // random boards back to back then with gaps
      repeat (150) send_board(random_board());
      repeat (150)
      begin
         send_board(random_board());
         gap = $unsigned($random(seed)) % 3;
         if (gap > 0)
            idle(gap);
      end
      drain();
      finish_run();
   end

endmodule

//--- vlog.f
verilog/pawn_eval_pkg.sv
verilog/pawn_board_decode.sv
verilog/pawn_structure_eval.sv
verilog/passed_pawn_eval.sv
verilog/evaluate_pawns.sv
verification/evaluate_pawns_props.sv
verification/tb_evaluate_pawns.sv

//--- Bender.yml
package:
  name: evaluate_pawns

sources:
  - verilog/pawn_eval_pkg.sv
  - verilog/pawn_board_decode.sv
  - verilog/pawn_structure_eval.sv
  - verilog/passed_pawn_eval.sv
  - verilog/evaluate_pawns.sv
  - target: test
    files:
      - verification/evaluate_pawns_props.sv
      - verification/tb_evaluate_pawns.sv
